//--- Makefile
# Verilator build and run for the F100 testbench.

VERILATOR ?= verilator
TOP       ?= f100_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= STATUS: PASS
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard verilog/*.sv tests/*.sv include/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log search decides the result, so a fatal stop also fails.
run: compile
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- files.f
+incdir+include
verilog/f100_pkg.sv
verilog/f100_alu.sv
verilog/f100_regs.sv
verilog/f100_control.sv
verilog/f100_memory.sv
verilog/f100_top.sv
tests/f100_properties.sv
tests/f100_tb.sv

//--- include/f100_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// F100 core constants: widths, start address,
// instruction fields and condition register bits.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef F100_PARAMS_SVH
`define F100_PARAMS_SVH

`define F100_WORD_W     16
`define F100_ADDR_W     16
`define F100_MEM_WORDS  2048
`define F100_START_PC   16'h0100
`define F100_HALT_WORD  16'h0400

// Instruction fields.
`define F100_OP_MSB     15
`define F100_OP_LSB     12
`define F100_ADDR_MSB   10
`define F100_ADDR_LSB   0

// Condition register bits.
`define F100_CR_M       5
`define F100_CR_C       4
`define F100_CR_S       3
`define F100_CR_V       2
`define F100_CR_Z       1

`endif

//--- tests/f100_properties.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// F100 host handshake and memory request checks.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module f100_properties (
  input logic                raw_clk,
  input logic                button_reset,
  input logic                run,
  input f100_pkg::host_req_t host_req,
  input logic                host_ready,
  input logic                host_rvalid,
  input f100_pkg::status_t   status,
  input f100_pkg::state_e    state,
  input f100_pkg::mem_req_t  mem_req
);

  // An accepted host read answers on the next cycle.
  read_returns_data: assert property (@(posedge raw_clk) disable iff (!button_reset)
    host_req.valid && host_ready && !host_req.write |=> host_rvalid)
    else $error("host read accepted without host_rvalid one cycle later");

  // A running sequencer owns the memory, so the host gets no read data back.
  host_only_when_stopped: assert property (@(posedge raw_clk) disable iff (!button_reset)
    (state != f100_pkg::IDLE) && (state != f100_pkg::HALTED) |=> !host_rvalid)
    else $error("host read answered while the sequencer runs");

  halt_is_sticky: assert property (@(posedge raw_clk) disable iff (!button_reset)
    status.halted && run |=> status.halted)
    else $error("halted dropped while run stayed high");

  // Core requests never overlap the host window.
  core_owns_port: assert property (@(posedge raw_clk) disable iff (!button_reset)
    mem_req.valid |-> !host_ready)
    else $error("core memory request while the host owns the port");

endmodule

bind f100_top f100_properties props0 (
  .raw_clk      (raw_clk),
  .button_reset (button_reset),
  .run          (run),
  .host_req     (host_req),
  .host_ready   (host_ready),
  .host_rvalid  (host_rvalid),
  .status       (status),
  .state        (state),
  .mem_req      (mem_req)
);

//--- tests/f100_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the F100 processor top.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "f100_params.svh"

module f100_tb;

  localparam int          CLK_PERIOD  = 8;
  localparam int          NUM_TESTS   = 5;
  localparam int          TEST_CYCLES = 200;
  localparam logic [15:0] HALT        = `F100_HALT_WORD;

  logic                raw_clk;
  logic                button_reset;
  logic                run;
  f100_pkg::host_req_t host_req;
  logic                host_ready;
  logic [15:0]         host_rdata;
  logic                host_rvalid;
  f100_pkg::status_t   status;

  logic [31:0] rng_state;
  logic [15:0] prog_q[$];
  logic [15:0] exp_acc;
  logic [15:0] exp_cr;

  f100_top dut0 (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .run          (run),
    .host_req     (host_req),
    .host_ready   (host_ready),
    .host_rdata   (host_rdata),
    .host_rvalid  (host_rvalid),
    .status       (status)
  );

  initial
  begin
    raw_clk = 1'b0;
    forever #(CLK_PERIOD / 2) raw_clk = ~raw_clk;
  end

  // Watchdog sized from the number of tests.
  initial
  begin
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    stop_on_error("Simulation timed out before all tests finished");
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "stopped at time %0t", $time);
  endtask

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (actual !== expected)
      stop_on_error($sformatf("Fail at %0t ns: %s expected %h got %h",
                              $time, name, expected, actual));
  endtask

  // Inputs change 1 ns after the rising edge.
  task automatic step();
    @(posedge raw_clk);
    #1;
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_word(output logic [15:0] w);
    rng_state = xorshift32(rng_state);
    w = rng_state[15:0];
  endtask

  function automatic logic [15:0] encode(input f100_pkg::opcode_e op, input logic [10:0] field);
    return {op, 1'b0, field};
  endfunction

  // F100-L operand rules, returned as {V, C, result}.
  function automatic logic [17:0] expect_alu(input f100_pkg::opcode_e op,
                                             input logic [15:0] acc, input logic [15:0] d,
                                             input logic m, input logic c);
    logic [16:0] sum;
    logic        v;
    sum = {1'b0, d};
    v   = 1'b0;
    case (op)
      f100_pkg::OP_ADD:
      begin
        sum = {1'b0, d} + {1'b0, acc} + {16'h0000, m & c};
        v   = (d[15] == acc[15]) && (sum[15] != d[15]);
      end
      f100_pkg::OP_SUB,
      f100_pkg::OP_CMP:
      begin
        // Data minus accumulator, one more borrowed when M is set and C is clear.
        sum = {1'b0, d} - {1'b0, acc} - {16'h0000, m & ~c};
        v   = (d[15] != acc[15]) && (sum[15] != d[15]);
      end
      f100_pkg::OP_AND: sum = {1'b0, acc & d};
      f100_pkg::OP_NEQ: sum = {1'b0, acc ^ d};
      default:          sum = {1'b0, d};
    endcase
    return {v, sum};
  endfunction

  // Moves the expected accumulator and flags through one instruction.
  task automatic apply_op(input f100_pkg::opcode_e op, input logic [15:0] d);
    logic [17:0] r;
    r = expect_alu(op, exp_acc, d, exp_cr[`F100_CR_M], exp_cr[`F100_CR_C]);
    exp_cr[`F100_CR_C] = r[16];
    exp_cr[`F100_CR_S] = r[15];
    exp_cr[`F100_CR_Z] = (r[15:0] == 16'h0000);
    if (op == f100_pkg::OP_ADD || op == f100_pkg::OP_SUB)
      exp_cr[`F100_CR_V] = r[17];
    if (op == f100_pkg::OP_CMP)
      exp_cr[`F100_CR_M] = 1'b1;
    else
      exp_acc = r[15:0];
  endtask

  task automatic check_regs();
    check_value("status.halted", 16'd1, status.halted);
    check_value("status.accum", exp_acc, status.accum);
    check_value("status.cr", exp_cr, status.cr);
  endtask

  task automatic apply_reset();
    button_reset = 1'b0;
    repeat (3) step();
    button_reset = 1'b1;
    exp_acc = 16'h0000;
    exp_cr  = 16'h0000;
  endtask

  task automatic host_xfer(input logic write, input logic [15:0] addr,
                           input logic [15:0] wdata, output logic [15:0] rdata);
    int waited;
    waited = 0;
    host_req.valid = 1'b1;
    host_req.write = write;
    host_req.addr  = addr;
    host_req.wdata = wdata;
    while (!host_ready)
    begin
      step();
      waited++;
      if (waited > 50)
        stop_on_error("Host port never became ready");
    end
    // Accepted on this edge.
    step();
    host_req.valid = 1'b0;
    rdata = host_rdata;
    if (!write)
      check_value("host_rvalid", 16'd1, host_rvalid);
  endtask

  task automatic host_write(input logic [15:0] addr, input logic [15:0] data);
    logic [15:0] unused;
    host_xfer(1'b1, addr, data, unused);
  endtask

  task automatic load_program();
    foreach (prog_q[i])
      host_write(16'(`F100_START_PC + i), prog_q[i]);
  endtask

  task automatic run_program(output int cycles);
    run    = 1'b1;
    cycles = 0;
    while (!status.halted)
    begin
      step();
      cycles++;
      if (cycles > 150)
        stop_on_error("Program did not reach its halt instruction");
    end
  endtask

  task automatic stop_program();
    run = 1'b0;
    step();
    check_value("status.halted", 16'd0, status.halted);
    check_value("host_ready", 16'd1, host_ready);
  endtask

  task automatic after_reset();
    apply_reset();
    check_value("host_ready", 16'd1, host_ready);
    check_value("host_rvalid", 16'd0, host_rvalid);
    check_value("status.halted", 16'd0, status.halted);
    check_value("status.accum", 16'h0000, status.accum);
    check_value("status.pc", 16'h0000, status.pc);
    check_value("status.cr", 16'h0000, status.cr);
  endtask

  task automatic host_round_trip();
    logic [15:0] addr;
    logic [15:0] data;
    logic [15:0] upper;
    logic [15:0] got;
    for (int i = 0; i < 8; i++)
    begin
      next_word(addr);
      next_word(data);
      next_word(upper);
      host_write(addr, data);
      // Address bits above the depth select the same word.
      host_xfer(1'b0, {upper[15:11], addr[10:0]}, 16'h0000, got);
      check_value("host_rdata", data, got);
    end
  endtask

  task automatic load_and_store();
    logic [15:0] k;
    logic [15:0] got;
    int          cycles;
    apply_reset();
    next_word(k);
    host_write(16'h0240, ~k);
    prog_q.delete();
    prog_q.push_back(encode(f100_pkg::OP_LDA, 11'h000));
    prog_q.push_back(k);
    prog_q.push_back(encode(f100_pkg::OP_STO, 11'h240));
    prog_q.push_back(HALT);
    load_program();
    apply_op(f100_pkg::OP_LDA, k);
    run_program(cycles);
    // Start step, LDA 6, STO 5 and halt 3 cycles.
    check_value("halt cycles", 16'd15, 16'(cycles));
    check_value("status.pc", 16'(`F100_START_PC + 4), status.pc);
    check_regs();
    stop_program();
    host_xfer(1'b0, 16'h0240, 16'h0000, got);
    check_value("mem[0x240]", k, got);
  endtask

  task automatic arithmetic_ops();
    f100_pkg::opcode_e ops[0:3];
    logic [15:0]       a;
    logic [15:0]       b;
    logic [15:0]       got;
    int                cycles;
    ops[0] = f100_pkg::OP_ADD;
    ops[1] = f100_pkg::OP_SUB;
    ops[2] = f100_pkg::OP_AND;
    ops[3] = f100_pkg::OP_NEQ;
    foreach (ops[i])
    begin
      apply_reset();
      next_word(a);
      next_word(b);
      host_write(16'h0200, b);
      prog_q.delete();
      prog_q.push_back(encode(f100_pkg::OP_LDA, 11'h000));
      prog_q.push_back(a);
      prog_q.push_back(encode(ops[i], 11'h200));
      prog_q.push_back(encode(f100_pkg::OP_STO, 11'h201));
      prog_q.push_back(HALT);
      load_program();
      apply_op(f100_pkg::OP_LDA, a);
      apply_op(ops[i], b);
      run_program(cycles);
      check_regs();
      stop_program();
      host_xfer(1'b0, 16'h0201, 16'h0000, got);
      check_value("mem[0x201]", exp_acc, got);
    end
  endtask

  task automatic compare_then_add();
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] c;
    int          cycles;
    for (int iter = 0; iter < 2; iter++)
    begin
      apply_reset();
      next_word(a);
      next_word(b);
      next_word(c);
      // First pass forces a borrow, so the ADD sees C set.
      if (iter == 0)
      begin
        a = a | 16'h8000;
        b = a >> 1;
      end
      host_write(16'h0210, b);
      host_write(16'h0211, c);
      prog_q.delete();
      prog_q.push_back(encode(f100_pkg::OP_LDA, 11'h000));
      prog_q.push_back(a);
      prog_q.push_back(encode(f100_pkg::OP_CMP, 11'h210));
      prog_q.push_back(HALT);
      load_program();
      apply_op(f100_pkg::OP_LDA, a);
      apply_op(f100_pkg::OP_CMP, b);
      run_program(cycles);
      check_regs();
      stop_program();
      // Second program runs with M and C left by the compare.
      prog_q.delete();
      prog_q.push_back(encode(f100_pkg::OP_ADD, 11'h211));
      prog_q.push_back(HALT);
      load_program();
      apply_op(f100_pkg::OP_ADD, c);
      run_program(cycles);
      check_regs();
      stop_program();
    end
  endtask

  task automatic jump_and_illegal();
    logic [15:0] k;
    logic [15:0] j;
    logic [15:0] got;
    int          cycles;
    apply_reset();
    next_word(k);
    next_word(j);
    host_write(16'h0220, ~k);
    prog_q.delete();
    prog_q.push_back(encode(f100_pkg::OP_LDA, 11'h000));
    prog_q.push_back(k);
    prog_q.push_back(encode(f100_pkg::OP_JMP, 11'h104));
    prog_q.push_back(HALT);
    prog_q.push_back(encode(f100_pkg::OP_STO, 11'h220));
    prog_q.push_back(HALT);
    load_program();
    apply_op(f100_pkg::OP_LDA, k);
    run_program(cycles);
    // Start step, LDA 6, JMP 3, STO 5 and halt 3 cycles.
    check_value("halt cycles", 16'd18, 16'(cycles));
    check_value("status.pc", 16'(`F100_START_PC + 6), status.pc);
    check_regs();
    stop_program();
    host_xfer(1'b0, 16'h0220, 16'h0000, got);
    check_value("mem[0x220]", k, got);
    // Opcode 3 is not supported and stops the core.
    prog_q.delete();
    prog_q.push_back(encode(f100_pkg::OP_LDA, 11'h000));
    prog_q.push_back(j);
    prog_q.push_back(16'h3000);
    prog_q.push_back(HALT);
    load_program();
    apply_op(f100_pkg::OP_LDA, j);
    run_program(cycles);
    check_value("status.pc", 16'(`F100_START_PC + 3), status.pc);
    check_regs();
    stop_program();
  endtask

  initial
  begin
    button_reset = 1'b0;
    run          = 1'b0;
    host_req     = '0;
    rng_state    = 32'haa090a55;
    exp_acc      = 16'h0000;
    exp_cr       = 16'h0000;
    after_reset();
    host_round_trip();
    load_and_store();
    arithmetic_ops();
    compare_then_add();
    jump_and_illegal();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- verilog/f100_alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// F100 ALU: result, carry and overflow per opcode.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "f100_params.svh"

module f100_alu (
  input  f100_pkg::opcode_e        op,
  input  logic [`F100_WORD_W-1:0]  accum,
  input  logic [`F100_WORD_W-1:0]  data,
  input  logic                     flag_m,
  input  logic                     flag_c,
  output logic [`F100_WORD_W-1:0]  result,
  output logic                     carry,
  output logic                     overflow
);

  localparam int MSB = `F100_WORD_W - 1;

  logic [`F100_WORD_W:0] wide;
  logic [`F100_WORD_W:0] carry_in;
  logic [`F100_WORD_W:0] borrow_adj;

  // In multi-length mode ADD folds in the carry.
  assign carry_in = {{`F100_WORD_W{1'b0}}, flag_m & flag_c};

  // Subtract adds C minus one when M is set, so either 0 or all ones.
  assign borrow_adj = flag_m ? ({{`F100_WORD_W{1'b0}}, flag_c} - 1'b1) : '0;

  // Subtraction is data minus accumulator, as on the F100-L.
  always_comb
  begin
    case (op)
      f100_pkg::OP_ADD: wide = {1'b0, data} + {1'b0, accum} + carry_in;
      f100_pkg::OP_SUB,
      f100_pkg::OP_CMP: wide = {1'b0, data} - {1'b0, accum} + borrow_adj;
      f100_pkg::OP_AND: wide = {1'b0, accum & data};
      f100_pkg::OP_NEQ: wide = {1'b0, accum ^ data};
      default:          wide = {1'b0, data};
    endcase
  end

  assign result = wide[MSB:0];
  assign carry  = wide[`F100_WORD_W];

  // Sign rule for overflow.
  always_comb
  begin
    case (op)
      f100_pkg::OP_ADD:
        overflow = (accum[MSB] == data[MSB]) && (result[MSB] != accum[MSB]);
      f100_pkg::OP_SUB,
      f100_pkg::OP_CMP:
        overflow = (accum[MSB] != data[MSB]) && (result[MSB] == accum[MSB]);
      default:
        overflow = 1'b0;
    endcase
  end

endmodule

//--- verilog/f100_control.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// F100 sequencer: fetch, decode, operand read,
// execute and write-back of one instruction.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "f100_params.svh"

module f100_control (
  input  logic                     raw_clk,
  input  logic                     button_reset,
  input  logic                     run,
  input  logic [`F100_WORD_W-1:0]  rdata,
  input  logic [`F100_WORD_W-1:0]  accum,
  input  logic [`F100_ADDR_W-1:0]  pc,
  input  logic [`F100_WORD_W-1:0]  alu_result,
  input  logic                     alu_carry,
  input  logic                     alu_overflow,
  output f100_pkg::mem_req_t       mem_req,
  output f100_pkg::reg_cmd_t       reg_cmd,
  output f100_pkg::opcode_e        alu_op,
  output logic [`F100_WORD_W-1:0]  operand,
  output f100_pkg::state_e         state
);

  localparam int AW = `F100_ADDR_W;

  // Second cycle of a two-cycle memory read.
  logic                    phase;
  logic [`F100_WORD_W-1:0] instr;
  logic [`F100_ADDR_W-1:0] ea;
  f100_pkg::alu_dest_e     dest;

  logic [`F100_ADDR_MSB:`F100_ADDR_LSB] addr_field;
  logic                    dec_imm;
  logic                    dec_halt;
  logic [`F100_ADDR_W-1:0] dec_ea;
  f100_pkg::alu_dest_e     dec_dest;

  assign alu_op     = f100_pkg::opcode_e'(instr[`F100_OP_MSB:`F100_OP_LSB]);
  assign addr_field = instr[`F100_ADDR_MSB:`F100_ADDR_LSB];

  // A zero address field means the operand is the next word.
  assign dec_imm = (addr_field == '0);
  assign dec_ea  = dec_imm ? pc : AW'(addr_field);

  always_comb
  begin
    dec_halt = 1'b0;
    dec_dest = f100_pkg::NONE;
    case (alu_op)
      f100_pkg::OP_LDA,
      f100_pkg::OP_ADD,
      f100_pkg::OP_SUB,
      f100_pkg::OP_AND,
      f100_pkg::OP_NEQ: dec_dest = f100_pkg::ACCUM;
      f100_pkg::OP_CMP: dec_dest = f100_pkg::NONE;
      f100_pkg::OP_STO: dec_dest = f100_pkg::MEMORY;
      f100_pkg::OP_JMP: dec_dest = f100_pkg::PC;
      default:          dec_halt = 1'b1;
    endcase
    if (instr == `F100_HALT_WORD)
      dec_halt = 1'b1;
  end

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state <= f100_pkg::IDLE;
      phase <= 1'b0;
      dest  <= f100_pkg::NONE;
    end
    else
    begin
      case (state)
        f100_pkg::IDLE:
          if (run)
            state <= f100_pkg::FETCH;
        f100_pkg::FETCH:
        begin
          phase <= ~phase;
          if (phase)
            state <= f100_pkg::DECODE;
        end
        f100_pkg::DECODE:
        begin
          dest <= dec_dest;
          if (dec_halt)
            state <= f100_pkg::HALTED;
          else if (dec_dest == f100_pkg::PC)
            state <= f100_pkg::FETCH;
          else if (dec_dest == f100_pkg::MEMORY)
            state <= f100_pkg::EXECUTE;
          else
            state <= f100_pkg::OPERAND;
        end
        f100_pkg::OPERAND:
        begin
          phase <= ~phase;
          if (phase)
            state <= f100_pkg::EXECUTE;
        end
        f100_pkg::EXECUTE:
          state <= (dest == f100_pkg::MEMORY) ? f100_pkg::WRITE : f100_pkg::FETCH;
        f100_pkg::WRITE:
          state <= f100_pkg::FETCH;
        f100_pkg::HALTED:
          if (!run)
            state <= f100_pkg::IDLE;
        default:
          state <= f100_pkg::IDLE;
      endcase
    end
  end

  // Instruction, address and operand capture.
  always_ff @(posedge raw_clk)
  begin
    if (state == f100_pkg::FETCH && phase)
      instr <= rdata;
    if (state == f100_pkg::DECODE)
      ea <= dec_ea;
    if (state == f100_pkg::OPERAND && phase)
      operand <= rdata;
  end

  // Reads go out in the first cycle, data comes back in the second.
  always_comb
  begin
    mem_req = '0;
    case (state)
      f100_pkg::FETCH:
      begin
        mem_req.valid = ~phase;
        mem_req.addr  = pc;
      end
      f100_pkg::OPERAND:
      begin
        mem_req.valid = ~phase;
        mem_req.addr  = ea;
      end
      f100_pkg::WRITE:
      begin
        mem_req.valid = 1'b1;
        mem_req.write = 1'b1;
        mem_req.addr  = ea;
        mem_req.wdata = accum;
      end
      default:
        mem_req.valid = 1'b0;
    endcase
  end

  always_comb
  begin
    reg_cmd          = '0;
    reg_cmd.pc_value = dec_ea;
    reg_cmd.result   = alu_result;
    reg_cmd.carry    = alu_carry;
    reg_cmd.overflow = alu_overflow;
    case (state)
      f100_pkg::IDLE:
      begin
        reg_cmd.pc_load  = run;
        reg_cmd.pc_value = `F100_START_PC;
      end
      f100_pkg::FETCH:
        reg_cmd.pc_inc = ~phase;
      f100_pkg::DECODE:
      begin
        // JMP finishes here; an immediate operand steps past its word.
        reg_cmd.pc_load = ~dec_halt && (dec_dest == f100_pkg::PC);
        reg_cmd.pc_inc  = ~dec_halt && dec_imm;
      end
      f100_pkg::EXECUTE:
      begin
        reg_cmd.acc_load   = (dest == f100_pkg::ACCUM);
        reg_cmd.flags_load = (dest != f100_pkg::MEMORY);
        reg_cmd.v_load     = (alu_op == f100_pkg::OP_ADD) || (alu_op == f100_pkg::OP_SUB);
        reg_cmd.set_m      = (alu_op == f100_pkg::OP_CMP);
      end
      default:
        reg_cmd.pc_inc = 1'b0;
    endcase
  end

endmodule

//--- verilog/f100_memory.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// F100 word memory shared by the core and the host.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "f100_params.svh"

module f100_memory (
  input  logic                     raw_clk,
  input  f100_pkg::mem_req_t       mem_req,
  output logic [`F100_WORD_W-1:0]  rdata,
  input  f100_pkg::host_req_t      host_req,
  output logic                     host_ready,
  output logic [`F100_WORD_W-1:0]  host_rdata,
  output logic                     host_rvalid,
  input  f100_pkg::state_e         cpu_state
);

  localparam int AW = $clog2(`F100_MEM_WORDS);

  logic [`F100_WORD_W-1:0] mem [0:`F100_MEM_WORDS-1];
  logic [`F100_WORD_W-1:0] read_q;

  logic                    port_valid;
  logic                    port_write;
  logic [AW-1:0]           port_addr;
  logic [`F100_WORD_W-1:0] port_wdata;

  // The host gets the port only while the core is stopped.
  assign host_ready = (cpu_state == f100_pkg::IDLE) || (cpu_state == f100_pkg::HALTED);

  always_comb
  begin
    if (host_ready)
    begin
      port_valid = host_req.valid;
      port_write = host_req.write;
      port_addr  = host_req.addr[AW-1:0];
      port_wdata = host_req.wdata;
    end
    else
    begin
      port_valid = mem_req.valid;
      port_write = mem_req.write;
      port_addr  = mem_req.addr[AW-1:0];
      port_wdata = mem_req.wdata;
    end
  end

  always_ff @(posedge raw_clk)
  begin
    if (port_valid && port_write)
      mem[port_addr] <= port_wdata;
    else if (port_valid)
      read_q <= mem[port_addr];
    host_rvalid <= host_ready && host_req.valid && !host_req.write;
  end

  // One read register serves both sides
  assign rdata      = read_q;
  assign host_rdata = read_q;

endmodule

//--- verilog/f100_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// F100 types: opcodes, sequencer states and the
// request, command and status structs.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "f100_params.svh"

package f100_pkg;

  typedef enum logic [3:0] {
    OP_STO = 4'h4,
    OP_LDA = 4'h8,
    OP_ADD = 4'h9,
    OP_SUB = 4'hA,
    OP_CMP = 4'hB,
    OP_AND = 4'hC,
    OP_NEQ = 4'hD,
    OP_JMP = 4'hF
  } opcode_e;

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    DECODE,
    OPERAND,
    EXECUTE,
    WRITE,
    HALTED
  } state_e;

  typedef enum logic [1:0] {
    NONE,
    ACCUM,
    MEMORY,
    PC
  } alu_dest_e;

  typedef struct packed {
    logic                    valid;
    logic                    write;
    logic [`F100_ADDR_W-1:0] addr;
    logic [`F100_WORD_W-1:0] wdata;
  } mem_req_t;

  // Same layout as mem_req_t, kept apart so the two ports cannot be swapped.
  typedef struct packed {
    logic                    valid;
    logic                    write;
    logic [`F100_ADDR_W-1:0] addr;
    logic [`F100_WORD_W-1:0] wdata;
  } host_req_t;

  typedef struct packed {
    logic                    pc_load;
    logic                    pc_inc;
    logic [`F100_ADDR_W-1:0] pc_value;
    logic                    acc_load;
    logic                    flags_load;
    logic                    v_load;
    logic                    set_m;
    logic [`F100_WORD_W-1:0] result;
    logic                    carry;
    logic                    overflow;
  } reg_cmd_t;

  typedef struct packed {
    logic [`F100_WORD_W-1:0] accum;
    logic [`F100_ADDR_W-1:0] pc;
    logic [`F100_WORD_W-1:0] cr;
    logic                    halted;
  } status_t;

endpackage

//--- verilog/f100_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// F100 registers: accumulator, program counter and
// condition register with flag update.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "f100_params.svh"

module f100_regs (
  input  logic                raw_clk,
  input  logic                button_reset,
  input  f100_pkg::reg_cmd_t  reg_cmd,
  input  logic                halted,
  output f100_pkg::status_t   status
);

  logic [`F100_WORD_W-1:0] accum;
  logic [`F100_ADDR_W-1:0] pc;
  logic [`F100_WORD_W-1:0] cr;

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      accum <= '0;
      pc    <= '0;
      cr    <= '0;
    end
    else
    begin
      // A load wins over the increment.
      if (reg_cmd.pc_load)
        pc <= reg_cmd.pc_value;
      else if (reg_cmd.pc_inc)
        pc <= pc + 1'b1;

      if (reg_cmd.acc_load)
        accum <= reg_cmd.result;

      if (reg_cmd.flags_load)
      begin
        cr[`F100_CR_C] <= reg_cmd.carry;
        cr[`F100_CR_S] <= reg_cmd.result[`F100_WORD_W-1];
        cr[`F100_CR_Z] <= (reg_cmd.result == '0);
        // V only moves on ADD and SUB.
        if (reg_cmd.v_load)
          cr[`F100_CR_V] <= reg_cmd.overflow;
      end

      if (reg_cmd.set_m)
        cr[`F100_CR_M] <= 1'b1;
    end
  end

  always_comb
  begin
    status.accum  = accum;
    status.pc     = pc;
    status.cr     = cr;
    status.halted = halted;
  end

endmodule

//--- verilog/f100_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// F100 processor top: core, registers and memory.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "f100_params.svh"

module f100_top (
  input  logic                     raw_clk,
  input  logic                     button_reset,
  input  logic                     run,
  input  f100_pkg::host_req_t      host_req,
  output logic                     host_ready,
  output logic [`F100_WORD_W-1:0]  host_rdata,
  output logic                     host_rvalid,
  output f100_pkg::status_t        status
);

  f100_pkg::state_e        state;
  f100_pkg::mem_req_t      mem_req;
  f100_pkg::reg_cmd_t      reg_cmd;
  f100_pkg::opcode_e       alu_op;
  logic [`F100_WORD_W-1:0] rdata;
  logic [`F100_WORD_W-1:0] operand;
  logic [`F100_WORD_W-1:0] alu_result;
  logic                    alu_carry;
  logic                    alu_overflow;

  f100_control control0 (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .run          (run),
    .rdata        (rdata),
    .accum        (status.accum),
    .pc           (status.pc),
    .alu_result   (alu_result),
    .alu_carry    (alu_carry),
    .alu_overflow (alu_overflow),
    .mem_req      (mem_req),
    .reg_cmd      (reg_cmd),
    .alu_op       (alu_op),
    .operand      (operand),
    .state        (state)
  );

  f100_regs regs0 (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .reg_cmd      (reg_cmd),
    .halted       (state == f100_pkg::HALTED),
    .status       (status)
  );

  f100_alu alu0 (
    .op       (alu_op),
    .accum    (status.accum),
    .data     (operand),
    .flag_m   (status.cr[`F100_CR_M]),
    .flag_c   (status.cr[`F100_CR_C]),
    .result   (alu_result),
    .carry    (alu_carry),
    .overflow (alu_overflow)
  );

  f100_memory memory0 (
    .raw_clk     (raw_clk),
    .mem_req     (mem_req),
    .rdata       (rdata),
    .host_req    (host_req),
    .host_ready  (host_ready),
    .host_rdata  (host_rdata),
    .host_rvalid (host_rvalid),
    .cpu_state   (state)
  );

endmodule
